// ==== verilog.f ====
+incdir+verilog
verilog/core_pkg.sv
verilog/fetch_stage.sv
verilog/reg_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/mem_wb_stage.sv
verilog/cpu_top.sv
test/cpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module cpu_tb -o cpu_sim

# a $fatal in the testbench gives a nonzero exit status
./obj_dir/cpu_sim

// ==== test/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb import core_pkg::*;;

    localparam int MAX_DELAY = 3;
    localparam logic [1:0] R_IDLE = 2'd0;
    localparam logic [1:0] R_RISE = 2'd1;
    localparam logic [1:0] R_HIGH = 2'd2;
    localparam logic [1:0] R_FALL = 2'd3;

    logic   clk = 1'b0;
    logic   rst_n;
    pc_t    imem_addr;
    word_t  imem_data;
    logic   dmem_req;
    daddr_t dmem_addr;
    logic   dmem_we;
    word_t  dmem_wdata;
    word_t  dmem_rdata;
    logic   dmem_ack;
    wb_s    retire;
    logic   halted;

    word_t       imem [64];
    word_t       dmem [64];
    wb_s         exp_ret [$];
    daddr_t      exp_st_addr [$];
    word_t       exp_st_data [$];
    int          prog_len = 0;
    int          ret_idx = 0;
    int          st_idx = 0;
    logic [31:0] lfsr;
    logic [1:0]  resp_st;
    logic [1:0]  resp_cnt;

    cpu_top dut0 (
        .clk, .rst_n, .imem_addr, .imem_data, .dmem_req, .dmem_addr, .dmem_we,
        .dmem_wdata, .dmem_rdata, .dmem_ack, .retire, .halted
    );

    always #10 clk = ~clk;

    function automatic word_t enc_r(input int funct, input int alt, input int rd,
                                    input int rs1, input int rs2);
        return {5'(rs1), 5'(rd), 10'b0, 1'(alt), 5'(rs2), 3'(funct), 3'b000};
    endfunction

    function automatic word_t enc_i(input int op, input int funct, input int rd,
                                    input int rs1, input int imm);
        return {5'(rs1), 5'(rd), 16'(imm), 3'(funct), 3'(op)};
    endfunction

    // branches and stores share this layout
    function automatic word_t enc_s(input int funct, input int rs1, input int rs2,
                                    input int imm);
        return {5'(rs1), 16'(imm), 5'(rs2), 3'(funct), 3'b110};
    endfunction

    function automatic word_t enc_jump(input int off);
        return {1'b0, 25'(off), 3'b000, 3'b111};
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // combinational instruction memory
    assign imem_data = (imem_addr < 27'd256) ? imem[imem_addr[7:2]] : enc_i(4, 0, 0, 0, 0);

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_retire(input wb_s exp, input wb_s act);
        if (act.rd !== exp.rd) begin
            fail_now($sformatf("MISMATCH retire.rd expected %02h actual %02h",
                               exp.rd, act.rd));
        end else if (act.data !== exp.data) begin
            fail_now($sformatf("MISMATCH retire.data expected %08h actual %08h",
                               exp.data, act.data));
        end
    endtask

    task automatic check_store(input daddr_t exp_addr, input word_t exp_data,
                               input daddr_t act_addr, input word_t act_data);
        if (act_addr !== exp_addr) begin
            fail_now($sformatf("MISMATCH dmem_addr expected %08h actual %08h",
                               exp_addr, act_addr));
        end else if (act_data !== exp_data) begin
            fail_now($sformatf("MISMATCH dmem_wdata expected %08h actual %08h",
                               exp_data, act_data));
        end
    endtask

    // one program word, rd < 0 when nothing is written
    task automatic put(input word_t inst, input int rd, input word_t data);
        wb_s r;
        imem[prog_len] = inst;
        prog_len++;
        if (rd >= 0) begin
            r.valid = 1'b1;
            r.rd    = reg_idx_t'(rd);
            r.rd_we = 1'b1;
            r.data  = data;
            exp_ret.push_back(r);
        end
    endtask

    task automatic load_program();
        put(enc_i(4, 0, 1, 0, 5), 1, 32'h0000_0005);
        put(enc_i(4, 0, 2, 0, -3), 2, 32'hffff_fffd);
        put(enc_i(4, 0, 0, 0, 7), 0, 32'h0000_0007);      // x0 target
        put(enc_i(4, 0, 3, 0, 'h123), 3, 32'h0000_0123);
        put(enc_r(0, 0, 4, 1, 2), 4, 32'h0000_0002);      // add
        put(enc_r(0, 1, 5, 4, 1), 5, 32'hffff_fffd);      // sub
        put(enc_r(4, 0, 6, 5, 3), 6, 32'hffff_fede);      // xor
        put(enc_r(6, 0, 7, 6, 1), 7, 32'hffff_fedf);      // or
        put(enc_r(7, 0, 8, 7, 3), 8, 32'h0000_0003);      // and
        put(enc_r(1, 0, 9, 1, 8), 9, 32'h0000_0028);      // sll
        put(enc_r(5, 0, 10, 2, 8), 10, 32'h1fff_ffff);    // srl
        put(enc_r(5, 1, 11, 2, 8), 11, 32'hffff_ffff);    // sra
        put(enc_r(2, 0, 12, 2, 1), 12, 32'h0000_0001);    // slt
        put(enc_r(3, 0, 13, 2, 1), 13, 32'h0000_0000);    // sltu
        put(enc_i(5, 2, 14, 0, 'habcd), 14, 32'habcd_0000);  // lui
        put(enc_r(0, 0, 0, 14, 14), 0, 32'h579a_0000);
        put(enc_r(0, 0, 15, 0, 14), 15, 32'habcd_0000);   // x0 must read zero
        put(enc_i(4, 0, 16, 0, 8), 16, 32'h0000_0008);
        put(enc_s(6, 16, 14, 2), -1, '0);                 // sw to word 10
        put(enc_i(5, 0, 17, 16, 2), 17, 32'habcd_0000);   // lw
        put(enc_i(4, 0, 18, 17, 1), 18, 32'habcd_0001);   // load use
        put(enc_s(6, 16, 18, 3), -1, '0);
        put(enc_i(5, 0, 19, 16, 3), 19, 32'habcd_0001);
        put(enc_r(0, 0, 20, 19, 19), 20, 32'h579a_0002);
        put(enc_s(0, 1, 1, 2), -1, '0);                   // beq taken
        put(enc_i(4, 0, 21, 0, 'h66), -1, '0);
        put(enc_s(1, 1, 1, 2), -1, '0);                   // bne not taken
        put(enc_i(4, 0, 21, 0, 1), 21, 32'h0000_0001);
        put(enc_s(2, 2, 1, 2), -1, '0);                   // blt taken
        put(enc_i(4, 0, 22, 0, 'h66), -1, '0);
        put(enc_s(3, 2, 1, 2), -1, '0);                   // bge not taken
        put(enc_i(4, 0, 22, 0, 2), 22, 32'h0000_0002);
        put(enc_s(4, 1, 2, 2), -1, '0);                   // bltu taken
        put(enc_i(4, 0, 23, 0, 'h66), -1, '0);
        put(enc_s(5, 1, 2, 2), -1, '0);                   // bgeu not taken
        put(enc_i(4, 0, 23, 0, 3), 23, 32'h0000_0003);
        put(enc_s(0, 1, 2, 2), -1, '0);                   // beq not taken
        put(enc_s(1, 1, 2, 2), -1, '0);                   // bne taken
        put(enc_i(4, 0, 24, 0, 'h66), -1, '0);
        put(enc_s(2, 1, 2, 2), -1, '0);                   // blt not taken
        put(enc_s(3, 1, 2, 2), -1, '0);                   // bge taken
        put(enc_i(4, 0, 24, 0, 'h66), -1, '0);
        put(enc_s(4, 2, 1, 2), -1, '0);                   // bltu not taken
        put(enc_s(5, 2, 1, 2), -1, '0);                   // bgeu taken
        put(enc_i(4, 0, 24, 0, 'h66), -1, '0);
        put(enc_i(4, 0, 24, 0, 4), 24, 32'h0000_0004);
        put(enc_jump(2), -1, '0);
        put(enc_i(4, 0, 25, 0, 'h66), -1, '0);
        put(enc_i(7, 1, 25, 0, 2), 25, 32'h0000_00c4);    // jal, link of word 48
        put(enc_i(4, 0, 25, 0, 'h66), -1, '0);
        put(enc_i(4, 0, 26, 0, 'hd8), 26, 32'h0000_00d8);
        put(enc_i(7, 2, 27, 26, 0), 27, 32'h0000_00d0);   // jalr to word 54
        put(enc_i(4, 0, 27, 0, 'h66), -1, '0);
        put(enc_i(4, 0, 27, 0, 'h66), -1, '0);
        put(enc_i(4, 0, 28, 27, 1), 28, 32'h0000_00d1);
        put(enc_i(7, 7, 0, 0, 0), -1, '0);                // halt
        put(enc_i(4, 0, 29, 0, 'h66), -1, '0);
        exp_st_addr.push_back(30'd10);
        exp_st_data.push_back(32'habcd_0000);
        exp_st_addr.push_back(30'd11);
        exp_st_data.push_back(32'habcd_0001);
    endtask

    task automatic draw_delay(output logic [1:0] d);
        for (int b = 0; b < 2; b++) begin
            d[b] = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic serve_request();
        if (dmem_we) begin
            if (st_idx >= exp_st_addr.size()) begin
                fail_now("a store arrived that the program does not contain");
            end else begin
                check_store(exp_st_addr[st_idx], exp_st_data[st_idx], dmem_addr, dmem_wdata);
                st_idx++;
            end
            dmem[dmem_addr[5:0]] = dmem_wdata;
        end else begin
            dmem_rdata = dmem[dmem_addr[5:0]];
        end
    endtask

    // data memory responder, random delay on ack rise and release
    initial begin
        dmem_ack   = 1'b0;
        dmem_rdata = '0;
        resp_st    = R_IDLE;
        resp_cnt   = 2'd0;
        lfsr       = 32'hbd0a_c268;
        for (int i = 0; i < 64; i++) begin
            dmem[i] = 32'h5a00_0000 ^ (word_t'(i) * 32'h0001_0203);
        end
        forever begin
            @(negedge clk);
            if (resp_st == R_IDLE && dmem_req) begin
                draw_delay(resp_cnt);
                resp_st = R_RISE;
            end
            if (resp_st == R_RISE) begin
                if (resp_cnt == 2'd0) begin
                    serve_request();
                    dmem_ack = 1'b1;
                    resp_st  = R_HIGH;
                end else begin
                    resp_cnt = resp_cnt - 2'd1;
                end
            end else if (resp_st == R_HIGH && !dmem_req) begin
                draw_delay(resp_cnt);
                resp_st = R_FALL;
            end
            if (resp_st == R_FALL) begin
                if (resp_cnt == 2'd0) begin
                    dmem_ack = 1'b0;
                    resp_st  = R_IDLE;
                end else begin
                    resp_cnt = resp_cnt - 2'd1;
                end
            end
        end
    end

    // retire monitor
    always @(posedge clk) begin
        if (rst_n) begin
            if (halted && (retire.valid || dmem_req)) begin
                fail_now("the core kept working after it halted");
            end else if (retire.valid && retire.rd_we) begin
                if (ret_idx >= exp_ret.size()) begin
                    fail_now("more register writes retired than the program has");
                end else begin
                    check_retire(exp_ret[ret_idx], retire);
                    ret_idx++;
                end
            end
        end
    end

    initial begin
        @(posedge rst_n);
        repeat (prog_len * 40 * MAX_DELAY) @(posedge clk);
        fail_now("timeout, core did not halt");
    end

    initial begin
        rst_n = 1'b0;
        for (int i = 0; i < 64; i++) begin
            imem[i] = enc_i(4, 0, 0, 0, 0);  // nop
        end
        load_program();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        while (halted !== 1'b1) @(posedge clk);
        repeat (10) @(posedge clk);  // nothing may retire after halt
        if (ret_idx == exp_ret.size() && st_idx == exp_st_addr.size()) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            fail_now($sformatf("halted after %0d of %0d writes and %0d of %0d stores",
                               ret_idx, exp_ret.size(), st_idx, exp_st_addr.size()));
        end
    end

endmodule

// ==== verilog/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top import core_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    output pc_t    imem_addr,
    input  word_t  imem_data,
    output logic   dmem_req,
    output daddr_t dmem_addr,
    output logic   dmem_we,
    output word_t  dmem_wdata,
    input  word_t  dmem_rdata,
    input  logic   dmem_ack,
    output wb_s    retire,
    output logic   halted
);

    fd_s      fd;
    de_s      de;
    em_s      em;
    wb_s      wb;
    logic     mem_ready;  // global advance
    logic     dec_stall_n;
    logic     halt_seen;
    logic     redirect;
    pc_t      redirect_pc;
    logic     flush;
    word_t    alu_fwd;
    logic     alu_fwd_ok;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    rs1_data;
    word_t    rs2_data;

    fetch_stage fetch0 (
        .clk, .rst_n, .advance(mem_ready), .dec_stall_n, .redirect, .redirect_pc,
        .halt_seen, .imem_addr, .imem_data, .fd
    );

    decode_stage decode0 (
        .clk, .rst_n, .advance(mem_ready), .flush, .fd, .alu_fwd, .alu_fwd_ok, .wb,
        .rs1, .rs2, .rs1_data, .rs2_data, .de, .dec_stall_n, .halt_seen
    );

    reg_file regs0 (.clk, .rst_n, .rs1, .rs2, .rs1_data, .rs2_data, .wb);

    execute_stage execute0 (
        .clk, .rst_n, .advance(mem_ready), .de, .alu_fwd, .alu_fwd_ok, .redirect,
        .redirect_pc, .flush, .em
    );

    mem_wb_stage mem_wb0 (
        .clk, .rst_n, .em, .dmem_req, .dmem_addr, .dmem_we, .dmem_wdata, .dmem_rdata,
        .dmem_ack, .mem_ready, .wb, .halted
    );

    assign retire = wb;

endmodule

// ==== verilog/mem_wb_stage.sv ====
`timescale 1ns/1ps

module mem_wb_stage import core_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  em_s    em,
    output logic   dmem_req,
    output daddr_t dmem_addr,
    output logic   dmem_we,
    output word_t  dmem_wdata,
    input  word_t  dmem_rdata,
    input  logic   dmem_ack,
    output logic   mem_ready,
    output wb_s    wb,
    output logic   halted
);

    mem_state_t state;
    logic       is_mem;
    word_t      load_q;  // read data held from ack until release

    assign is_mem = em.valid && (em.mre || em.mwe);

    // em holds while mem_ready is low, so the request fields stay put
    assign dmem_req   = (state == wait_ack);
    assign dmem_addr  = em.daddr;
    assign dmem_we    = em.mwe;
    assign dmem_wdata = em.sdata;

    assign mem_ready = !is_mem || ((state == wait_release) && !dmem_ack);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            case (state)
                idle:         if (is_mem) state <= wait_ack;
                wait_ack:     if (dmem_ack) state <= wait_release;
                wait_release: if (!dmem_ack) state <= idle;
                default:      state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == wait_ack) && dmem_ack) begin
            load_q <= dmem_rdata;
        end
    end

    // write-back mux, valid in the cycle the instruction leaves
    always_comb begin
        wb.valid = em.valid && mem_ready;
        wb.rd    = em.rd;
        wb.rd_we = em.rd_we;
        wb.data  = em.mre ? load_q : em.result;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            halted <= 1'b0;
        end else if (wb.valid && em.halt) begin
            halted <= 1'b1;  // sticky
        end
    end

endmodule

// ==== verilog/execute_stage.sv ====
`timescale 1ns/1ps
`include "core_macros.svh"

module execute_stage import core_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  advance,
    input  de_s   de,
    output word_t alu_fwd,
    output logic  alu_fwd_ok,
    output logic  redirect,
    output pc_t   redirect_pc,
    output logic  flush,
    output em_s   em
);

    logic       alt;
    logic [2:0] op;
    logic [2:0] funct;
    logic [4:0] shamt;
    logic       eq;
    logic       lt;
    logic       ltu;
    logic [5:0] cond;
    logic       taken;
    word_t      result;

    assign alt   = de.aluctl[6];  // sub / sra select
    assign op    = de.aluctl[5:3];
    assign funct = de.aluctl[2:0];
    assign shamt = de.op2[4:0];

    assign eq  = (de.op1 == de.op2);
    assign lt  = ($signed(de.op1) < $signed(de.op2));
    assign ltu = (de.op1 < de.op2);

    always_comb begin
        if (op == `OP_J) begin
            result = de.op1 + de.op2;  // pc + 4
        end else if ((op == `OP_LD) && (funct == 3'b010)) begin
            result = {de.op2[15:0], 16'h0000};  // lui
        end else begin
            case (funct)
                3'b000:  result = (alt && (op == `OP_R)) ? de.op1 - de.op2 : de.op1 + de.op2;
                3'b001:  result = de.op1 << shamt;
                3'b010:  result = {{(`WORD_W-1){1'b0}}, lt};
                3'b011:  result = {{(`WORD_W-1){1'b0}}, ltu};
                3'b100:  result = de.op1 ^ de.op2;
                3'b101: begin
                    // sign fill only when the shift stands alone as a signed expression
                    if (alt) begin
                        result = $signed(de.op1) >>> shamt;
                    end else begin
                        result = de.op1 >> shamt;
                    end
                end
                3'b110:  result = de.op1 | de.op2;
                default: result = de.op1 & de.op2;
            endcase
        end
    end

    // eq ne lt ge ltu geu
    assign cond  = {!ltu, ltu, !lt, lt, !eq, eq};
    assign taken = de.jump || (de.branch_kind[6] && |(de.branch_kind[5:0] & cond));

    assign redirect    = de.valid && taken;
    assign redirect_pc = de.npc;
    assign flush       = redirect;

    assign alu_fwd    = result;
    assign alu_fwd_ok = de.valid && de.rd_we && de.is_alu;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            em <= '0;
        end else if (advance) begin
            em.valid  <= de.valid;
            em.rd     <= de.rd;
            em.rd_we  <= de.rd_we;
            em.mre    <= de.mre;
            em.mwe    <= de.mwe;
            em.result <= result;
            em.daddr  <= de.daddr;
            em.sdata  <= de.sdata;
            em.halt   <= de.halt;
        end
    end

endmodule

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ps
`include "core_macros.svh"

module decode_stage import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     advance,
    input  logic     flush,
    input  fd_s      fd,
    input  word_t    alu_fwd,
    input  logic     alu_fwd_ok,
    input  wb_s      wb,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    input  word_t    rs1_data,
    input  word_t    rs2_data,
    output de_s      de,
    output logic     dec_stall_n,
    output logic     halt_seen
);

    logic [2:0] op;
    logic [2:0] funct;
    reg_idx_t   rd;
    word_t      imm_il;
    word_t      imm_sb;
    word_t      rs1_val;
    word_t      rs2_val;
    word_t      op2;
    word_t      addr_sum;
    logic       is_jump;
    logic       is_jal;
    logic       is_jalr;
    logic       is_lui;
    logic       is_halt;
    logic       is_branch;
    logic       load_use;
    pc_t        npc;
    de_s        de_next;

    assign op     = fd.inst[2:0];
    assign funct  = fd.inst[5:3];
    assign rs1    = fd.inst[31:27];
    assign rs2    = fd.inst[10:6];
    assign rd     = fd.inst[26:22];
    assign imm_il = {{16{fd.inst[21]}}, fd.inst[21:6]};
    assign imm_sb = {{16{fd.inst[26]}}, fd.inst[26:11]};

    assign is_jump   = (op == `OP_J) && (funct == 3'b000);
    assign is_jal    = (op == `OP_J) && (funct == 3'b001);
    assign is_jalr   = (op == `OP_J) && (funct == 3'b010);
    assign is_halt   = (op == `OP_J) && (funct == 3'b111);
    assign is_lui    = (op == `OP_LD) && (funct == 3'b010);
    assign is_branch = (op == `OP_SB) && !(&funct[2:1]);

    // execute result first, then writeback, then the bank
    always_comb begin
        if (alu_fwd_ok && (rs1 == de.rd) && (rs1 != '0)) begin
            rs1_val = alu_fwd;
        end else if (wb.valid && wb.rd_we && (rs1 == wb.rd) && (rs1 != '0)) begin
            rs1_val = wb.data;
        end else begin
            rs1_val = rs1_data;
        end
        if (alu_fwd_ok && (rs2 == de.rd) && (rs2 != '0)) begin
            rs2_val = alu_fwd;
        end else if (wb.valid && wb.rd_we && (rs2 == wb.rd) && (rs2 != '0)) begin
            rs2_val = wb.data;
        end else begin
            rs2_val = rs2_data;
        end
    end

    always_comb begin
        case (op)
            `OP_I, `OP_LD: op2 = imm_il;
            `OP_J:         op2 = `WORD_W'd4;  // link offset
            default:       op2 = rs2_val;
        endcase
    end

    always_comb begin
        if (is_jump) begin
            npc = fd.pc + {fd.inst[30:6], 2'b00};
        end else if (is_jal) begin
            npc = fd.pc + {imm_il[`PC_W-3:0], 2'b00};
        end else if (is_jalr) begin
            npc = rs1_val[`PC_W-1:0] + {imm_il[`PC_W-3:0], 2'b00};
        end else begin
            npc = fd.pc + {imm_sb[`PC_W-3:0], 2'b00};  // branch target
        end
    end

    // loads use the I immediate, stores the S immediate
    assign addr_sum = (op[2] & op[0]) ? rs1_val + imm_il : rs1_val + imm_sb;

    // producer in execute is a load
    assign load_use = fd.valid && de.valid && de.mre && de.rd_we && (de.rd != '0) &&
                      ((de.rd == rs1) || (de.rd == rs2));
    assign dec_stall_n = !load_use;
    assign halt_seen   = fd.valid && is_halt;

    always_comb begin
        de_next.valid       = fd.valid;
        de_next.op1         = (op == `OP_J) ? {{(`WORD_W-`PC_W){1'b0}}, fd.pc} : rs1_val;
        de_next.op2         = op2;
        de_next.aluctl      = {fd.inst[11], op, funct};
        de_next.rd          = rd;
        de_next.rd_we       = (op[2:1] != 2'b11) || is_jal || is_jalr;
        de_next.mre         = (op == `OP_LD) && (funct[2:1] == 2'b00);
        de_next.mwe         = (op == `OP_SB) && (funct[2:1] == 2'b11);
        de_next.sdata       = rs2_val;
        de_next.daddr       = addr_sum[29:0];
        de_next.branch_kind = {is_branch, 6'b000001 << funct[2:0]};
        de_next.jump        = is_jump || is_jal || is_jalr;
        de_next.npc         = npc;
        de_next.is_alu      = !op[2] || (op == `OP_I) || is_lui || is_jal || is_jalr;
        de_next.halt        = is_halt;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            de <= '0;
        end else if (advance) begin
            if (flush || load_use) begin
                de <= '0;  // bubble
            end else begin
                de <= de_next;
            end
        end
    end

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps
`include "core_macros.svh"

module reg_file import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output word_t    rs1_data,
    output word_t    rs2_data,
    input  wb_s      wb
);

    word_t regs [`REG_CNT];

    logic wr_en;
    assign wr_en = wb.valid && wb.rd_we && (wb.rd != '0);  // x0 never written

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // same-cycle write is covered by decode forwarding
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== verilog/fetch_stage.sv ====
`timescale 1ns/1ps
`include "core_macros.svh"

module fetch_stage import core_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  advance,
    input  logic  dec_stall_n,
    input  logic  redirect,
    input  pc_t   redirect_pc,
    input  logic  halt_seen,
    output pc_t   imem_addr,
    input  word_t imem_data,
    output fd_s   fd
);

    pc_t  pc;
    logic stopped;  // halt went past decode

    assign imem_addr = pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc      <= `RESET_PC;
            stopped <= 1'b0;
            fd      <= '{valid: 1'b0, pc: `RESET_PC, inst: `NOP_INST};
        end else if (advance) begin
            if (redirect) begin
                // taken branch or jump in execute
                pc <= redirect_pc;
                fd <= '{valid: 1'b0, pc: redirect_pc, inst: `NOP_INST};
            end else if (!dec_stall_n) begin
                fd <= fd;  // load-use, decode keeps its word
            end else if (halt_seen || stopped) begin
                stopped <= 1'b1;
                fd      <= '{valid: 1'b0, pc: pc, inst: `NOP_INST};
            end else begin
                fd <= '{valid: 1'b1, pc: pc, inst: imem_data};
                pc <= pc + `PC_W'd4;
            end
        end
    end

endmodule

// ==== verilog/core_pkg.sv ====
`include "core_macros.svh"

package core_pkg;

    typedef logic [`WORD_W-1:0] word_t;
    typedef logic [`PC_W-1:0]   pc_t;
    typedef logic [4:0]         reg_idx_t;
    typedef logic [29:0]        daddr_t;   // word address into data memory
    typedef logic [6:0]         aluctl_t;  // {inst[11], op, funct}

    // data memory handshake
    typedef enum logic [1:0] {
        idle,
        wait_ack,
        wait_release
    } mem_state_t;

    typedef struct packed {
        logic  valid;
        pc_t   pc;
        word_t inst;
    } fd_s;

    typedef struct packed {
        logic       valid;
        word_t      op1;
        word_t      op2;
        aluctl_t    aluctl;
        reg_idx_t   rd;
        logic       rd_we;
        logic       mre;
        logic       mwe;
        word_t      sdata;
        daddr_t     daddr;
        logic [6:0] branch_kind;  // [5:0] eq ne lt ge ltu geu, [6] branch
        logic       jump;
        pc_t        npc;
        logic       is_alu;       // result ready at end of execute
        logic       halt;
    } de_s;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     rd_we;
        logic     mre;
        logic     mwe;
        word_t    result;
        daddr_t   daddr;
        word_t    sdata;
        logic     halt;
    } em_s;

    // register write, forwarding and retire
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     rd_we;
        word_t    data;
    } wb_s;

endpackage

// ==== verilog/core_macros.svh ====
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// data path width
`define WORD_W 32

// byte addressed program counter
`define PC_W 27

// integer register bank
`define REG_CNT 32

// first fetch after reset
`define RESET_PC 27'd0

// addi x0, x0, 0 (op 100, funct 000)
`define NOP_INST 32'h0000_0004

// op field values
`define OP_R    3'b000
`define OP_I    3'b100
`define OP_LD   3'b101
`define OP_SB   3'b110
`define OP_J    3'b111

`endif
